// ==== run.sh ====
#!/bin/sh
# Compile and run the memory-side testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_top -f vlog.f -o tb_top_sim

./obj_dir/tb_top_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "RESULT: PASS" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1

// ==== src/bgpu_mem_pkg.sv ====
// ############################
// Word, line and block widths of the shared memory
// Lines and blocks must divide the 128-bit word evenly
// ############################

package bgpu_mem_pkg;

    // ############################
    // Widths

    // One memory word
    localparam int unsigned MemWidth      = 128;
    // Encoded instruction
    localparam int unsigned EncInstWidth  = 32;
    // 2^IClineIdxBits instructions per line
    localparam int unsigned IClineIdxBits = 1;
    // 2^BlockIdxBits bytes per data block
    localparam int unsigned BlockIdxBits  = 2;

    localparam int unsigned ImemLineWidth = EncInstWidth << IClineIdxBits;
    localparam int unsigned BlockBytes    = 1 << BlockIdxBits;
    localparam int unsigned MemStrbWidth  = MemWidth / 8;

    // Byte offset bits inside one word and inside one instruction
    localparam int unsigned WordOffsetBits = $clog2(MemStrbWidth);
    localparam int unsigned InstOffsetBits = $clog2(EncInstWidth / 8);

    // How a word splits into lines and blocks
    localparam int unsigned LinesPerWord  = MemWidth / ImemLineWidth;
    localparam int unsigned BlocksPerWord = MemWidth / (BlockBytes * 8);

    // ############################
    // Types

    typedef logic [MemWidth-1:0]      mem_data_t;
    typedef logic [MemStrbWidth-1:0]  mem_strb_t;
    typedef logic [ImemLineWidth-1:0] imem_line_t;
    typedef logic [BlockBytes*8-1:0]  block_data_t;
    typedef logic [BlockBytes-1:0]    block_mask_t;

    // Same word seen by the fetch path as lines and by the data path as blocks
    typedef union packed {
        imem_line_t  [LinesPerWord-1:0]  lines;
        block_data_t [BlocksPerWord-1:0] blocks;
    } mem_word_u;

endpackage : bgpu_mem_pkg

// ==== src/bgpu_mem_top.sv ====
// ############################
// Fetch and data paths sharing one word memory
// Grants are combinational, rvalid one cycle after accept
// ############################

`timescale 1ns/1ps

module bgpu_mem_top #(
    parameter int unsigned MemAddrWidth = 12
) (
    input  logic clk_i,
    input  logic rst_i,

    // Instruction fetch
    input  logic                                             fetch_req_i,
    input  logic [MemAddrWidth-bgpu_mem_pkg::InstOffsetBits-1:0] fetch_pc_i,
    output logic                                             fetch_gnt_o,
    output logic                                             fetch_rvalid_o,
    output bgpu_mem_pkg::imem_line_t                         fetch_line_o,

    // Data access
    input  logic                      data_req_i,
    input  logic                      data_we_i,
    input  logic [MemAddrWidth-1:0]   data_addr_i,
    input  bgpu_mem_pkg::block_data_t data_wdata_i,
    input  bgpu_mem_pkg::block_mask_t data_be_i,
    output logic                      data_gnt_o,
    output logic                      data_rvalid_o,
    output bgpu_mem_pkg::block_data_t data_rdata_o
);
    localparam int unsigned WordAddrWidth = MemAddrWidth - bgpu_mem_pkg::WordOffsetBits;

    // ############################
    // Signals

    // Fetch port to arbiter
    logic                     if_req, if_gnt, if_rvalid;
    logic [WordAddrWidth-1:0] if_addr;

    // Data port to arbiter
    logic                     dp_req, dp_we, dp_gnt, dp_rvalid;
    logic [WordAddrWidth-1:0] dp_addr;
    bgpu_mem_pkg::mem_word_u  dp_wdata;
    bgpu_mem_pkg::mem_strb_t  dp_strb;

    // Shared read word
    bgpu_mem_pkg::mem_word_u  arb_rdata;

    // Arbiter to memory
    logic                     mem_req, mem_we;
    logic [WordAddrWidth-1:0] mem_addr;
    bgpu_mem_pkg::mem_data_t  mem_wdata, mem_rdata;
    bgpu_mem_pkg::mem_strb_t  mem_strb;

    // ############################
    // Request ports

    ifetch_port #(
        .MemAddrWidth( MemAddrWidth )
    ) i_ifetch_port (
        .clk_i         ( clk_i          ),
        .rst_i         ( rst_i          ),
        .fetch_req_i   ( fetch_req_i    ),
        .fetch_pc_i    ( fetch_pc_i     ),
        .fetch_gnt_o   ( fetch_gnt_o    ),
        .fetch_rvalid_o( fetch_rvalid_o ),
        .fetch_line_o  ( fetch_line_o   ),
        .mem_req_o     ( if_req         ),
        .mem_addr_o    ( if_addr        ),
        .mem_gnt_i     ( if_gnt         ),
        .mem_rvalid_i  ( if_rvalid      ),
        .mem_rdata_i   ( arb_rdata      )
    );

    data_port #(
        .MemAddrWidth( MemAddrWidth )
    ) i_data_port (
        .clk_i        ( clk_i         ),
        .rst_i        ( rst_i         ),
        .data_req_i   ( data_req_i    ),
        .data_we_i    ( data_we_i     ),
        .data_addr_i  ( data_addr_i   ),
        .data_wdata_i ( data_wdata_i  ),
        .data_be_i    ( data_be_i     ),
        .data_gnt_o   ( data_gnt_o    ),
        .data_rvalid_o( data_rvalid_o ),
        .data_rdata_o ( data_rdata_o  ),
        .mem_req_o    ( dp_req        ),
        .mem_we_o     ( dp_we         ),
        .mem_addr_o   ( dp_addr       ),
        .mem_wdata_o  ( dp_wdata      ),
        .mem_strb_o   ( dp_strb       ),
        .mem_gnt_i    ( dp_gnt        ),
        .mem_rvalid_i ( dp_rvalid     ),
        .mem_rdata_i  ( arb_rdata     )
    );

    // ############################
    // Arbiter and memory

    mem_arbiter #(
        .MemAddrWidth( MemAddrWidth )
    ) i_mem_arbiter (
        .clk_i         ( clk_i     ),
        .rst_i         ( rst_i     ),
        .fetch_req_i   ( if_req    ),
        .fetch_addr_i  ( if_addr   ),
        .fetch_gnt_o   ( if_gnt    ),
        .fetch_rvalid_o( if_rvalid ),
        .data_req_i    ( dp_req    ),
        .data_we_i     ( dp_we     ),
        .data_addr_i   ( dp_addr   ),
        .data_wdata_i  ( dp_wdata  ),
        .data_strb_i   ( dp_strb   ),
        .data_gnt_o    ( dp_gnt    ),
        .data_rvalid_o ( dp_rvalid ),
        .rdata_o       ( arb_rdata ),
        .mem_req_o     ( mem_req   ),
        .mem_we_o      ( mem_we    ),
        .mem_addr_o    ( mem_addr  ),
        .mem_wdata_o   ( mem_wdata ),
        .mem_strb_o    ( mem_strb  ),
        .mem_rdata_i   ( mem_rdata )
    );

    dummy_mem #(
        .MemAddrWidth( MemAddrWidth )
    ) i_dummy_mem (
        .clk_i  ( clk_i     ),
        .req_i  ( mem_req   ),
        .we_i   ( mem_we    ),
        .addr_i ( mem_addr  ),
        .wdata_i( mem_wdata ),
        .strb_i ( mem_strb  ),
        .rdata_o( mem_rdata )
    );

endmodule : bgpu_mem_top

// ==== src/data_port.sv ====
// ############################
// Byte address must be block aligned
// One block per request, byte mask applies to writes only
// ############################

`timescale 1ns/1ps

module data_port #(
    parameter int unsigned MemAddrWidth = 12
) (
    input  logic clk_i,
    input  logic rst_i,

    // Data requester
    input  logic                              data_req_i,
    input  logic                              data_we_i,
    input  logic [MemAddrWidth-1:0]           data_addr_i,
    input  bgpu_mem_pkg::block_data_t         data_wdata_i,
    input  bgpu_mem_pkg::block_mask_t         data_be_i,
    output logic                              data_gnt_o,
    output logic                              data_rvalid_o,
    output bgpu_mem_pkg::block_data_t         data_rdata_o,

    // Towards the arbiter
    output logic                              mem_req_o,
    output logic                              mem_we_o,
    output logic [MemAddrWidth-bgpu_mem_pkg::WordOffsetBits-1:0] mem_addr_o,
    output bgpu_mem_pkg::mem_word_u           mem_wdata_o,
    output bgpu_mem_pkg::mem_strb_t           mem_strb_o,
    input  logic                              mem_gnt_i,
    input  logic                              mem_rvalid_i,
    input  bgpu_mem_pkg::mem_word_u           mem_rdata_i
);
    localparam int unsigned LaneBits = $clog2(bgpu_mem_pkg::BlocksPerWord);

    logic [LaneBits-1:0] lane;
    logic [LaneBits-1:0] lane_q;

    // ############################
    // Request side

    assign mem_addr_o = data_addr_i[MemAddrWidth-1:bgpu_mem_pkg::WordOffsetBits];
    assign lane       = data_addr_i[bgpu_mem_pkg::BlockIdxBits +: LaneBits];

    assign mem_req_o  = data_req_i;
    assign mem_we_o   = data_we_i;
    assign data_gnt_o = mem_gnt_i;

    // Block copied into every lane, strobes open only the addressed one
    always_comb begin : build_write_word
        mem_wdata_o.blocks = {bgpu_mem_pkg::BlocksPerWord{data_wdata_i}};
        mem_strb_o         = '0;
        for (int unsigned i = 0; i < bgpu_mem_pkg::BlocksPerWord; i++) begin
            if (lane == LaneBits'(i)) begin
                mem_strb_o[i*bgpu_mem_pkg::BlockBytes +: bgpu_mem_pkg::BlockBytes] = data_be_i;
            end
        end
    end : build_write_word

    // ############################
    // Return side

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            lane_q <= '0;
        end else if (data_req_i && mem_gnt_i) begin
            lane_q <= lane;
        end
    end

    assign data_rvalid_o = mem_rvalid_i;
    assign data_rdata_o  = mem_rdata_i.blocks[lane_q];

    // ############################
    // Checks

    a_block_aligned : assert property (
        @(posedge clk_i) disable iff (rst_i)
        data_req_i |-> (data_addr_i[bgpu_mem_pkg::BlockIdxBits-1:0] == '0)
    ) else $error("data request to unaligned address %h", data_addr_i);

    // A waiting requester keeps its request and address until granted
    a_req_held : assert property (
        @(posedge clk_i) disable iff (rst_i)
        (data_req_i && !data_gnt_o) |=> (data_req_i && $stable(data_addr_i))
    ) else $error("data request dropped or changed before grant");

    // Lane register only holds for the cycle right after the accept
    a_rvalid_after_accept : assert property (
        @(posedge clk_i) disable iff (rst_i)
        1'b1 |=> (mem_rvalid_i == $past(data_req_i && mem_gnt_i))
    ) else $error("data return not one cycle after its accept");

endmodule : data_port

// ==== src/dummy_mem.sv ====
// ############################
// Starts at zero, reset leaves contents alone
// Read data one cycle after req, old data on a write
// ############################

`timescale 1ns/1ps

module dummy_mem #(
    parameter int unsigned MemAddrWidth = 12
) (
    input  logic                                             clk_i,
    input  logic                                             req_i,
    input  logic                                             we_i,
    input  logic [MemAddrWidth-bgpu_mem_pkg::WordOffsetBits-1:0] addr_i,
    input  bgpu_mem_pkg::mem_data_t                          wdata_i,
    input  bgpu_mem_pkg::mem_strb_t                          strb_i,
    output bgpu_mem_pkg::mem_data_t                          rdata_o
);
    localparam int unsigned WordAddrWidth = MemAddrWidth - bgpu_mem_pkg::WordOffsetBits;
    localparam int unsigned NumWords      = 1 << WordAddrWidth;

    bgpu_mem_pkg::mem_data_t mem_q [NumWords] = '{default: '0};

    // Byte-enabled write
    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            for (int unsigned b = 0; b < bgpu_mem_pkg::MemStrbWidth; b++) begin
                if (strb_i[b]) begin
                    mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    // Registered read port
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rdata_o <= mem_q[addr_i];
        end
    end

endmodule : dummy_mem

// ==== src/ifetch_port.sv ====
// ############################
// PC counts instructions, returns one full line
// Requester holds req and pc until granted
// ############################

`timescale 1ns/1ps

module ifetch_port #(
    parameter int unsigned MemAddrWidth = 12
) (
    input  logic clk_i,
    input  logic rst_i,

    // Fetch requester
    input  logic                                             fetch_req_i,
    input  logic [MemAddrWidth-bgpu_mem_pkg::InstOffsetBits-1:0] fetch_pc_i,
    output logic                                             fetch_gnt_o,
    output logic                                             fetch_rvalid_o,
    output bgpu_mem_pkg::imem_line_t                         fetch_line_o,

    // Towards the arbiter
    output logic                                             mem_req_o,
    output logic [MemAddrWidth-bgpu_mem_pkg::WordOffsetBits-1:0] mem_addr_o,
    input  logic                                             mem_gnt_i,
    input  logic                                             mem_rvalid_i,
    input  bgpu_mem_pkg::mem_word_u                          mem_rdata_i
);
    localparam int unsigned PcWidth       = MemAddrWidth - bgpu_mem_pkg::InstOffsetBits;
    localparam int unsigned WordAddrWidth = MemAddrWidth - bgpu_mem_pkg::WordOffsetBits;
    localparam int unsigned LineSelBits   = $clog2(bgpu_mem_pkg::LinesPerWord);

    // Line inside the word, remembered until the data comes back
    logic [LineSelBits-1:0] line_idx;
    logic [LineSelBits-1:0] line_idx_q;

    // Upper PC bits pick the word, the bits above the instruction index pick the line
    assign mem_addr_o = fetch_pc_i[PcWidth-1 -: WordAddrWidth];
    assign line_idx   = fetch_pc_i[bgpu_mem_pkg::IClineIdxBits +: LineSelBits];

    assign mem_req_o   = fetch_req_i;
    assign fetch_gnt_o = mem_gnt_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            line_idx_q <= '0;
        end else if (fetch_req_i && mem_gnt_i) begin
            line_idx_q <= line_idx;
        end
    end

    // Return cycle
    assign fetch_rvalid_o = mem_rvalid_i;
    assign fetch_line_o   = mem_rdata_i.lines[line_idx_q];

endmodule : ifetch_port

// ==== src/mem_arbiter.sv ====
// ############################
// Alternating priority, fetch first after reset
// Fetch requests are always reads
// ############################

`timescale 1ns/1ps

module mem_arbiter #(
    parameter int unsigned MemAddrWidth = 12
) (
    input  logic clk_i,
    input  logic rst_i,

    // Fetch source
    input  logic                                             fetch_req_i,
    input  logic [MemAddrWidth-bgpu_mem_pkg::WordOffsetBits-1:0] fetch_addr_i,
    output logic                                             fetch_gnt_o,
    output logic                                             fetch_rvalid_o,

    // Data source
    input  logic                                             data_req_i,
    input  logic                                             data_we_i,
    input  logic [MemAddrWidth-bgpu_mem_pkg::WordOffsetBits-1:0] data_addr_i,
    input  bgpu_mem_pkg::mem_word_u                          data_wdata_i,
    input  bgpu_mem_pkg::mem_strb_t                          data_strb_i,
    output logic                                             data_gnt_o,
    output logic                                             data_rvalid_o,

    // Read word shared by both sources
    output bgpu_mem_pkg::mem_word_u                          rdata_o,

    // Memory side
    output logic                                             mem_req_o,
    output logic                                             mem_we_o,
    output logic [MemAddrWidth-bgpu_mem_pkg::WordOffsetBits-1:0] mem_addr_o,
    output bgpu_mem_pkg::mem_data_t                          mem_wdata_o,
    output bgpu_mem_pkg::mem_strb_t                          mem_strb_o,
    input  bgpu_mem_pkg::mem_data_t                          mem_rdata_i
);
    // High while fetch wins a tie
    logic prio_fetch_q;

    // ############################
    // Grant

    assign fetch_gnt_o = fetch_req_i && (!data_req_i || prio_fetch_q);
    assign data_gnt_o  = data_req_i && (!fetch_req_i || !prio_fetch_q);

    // On a tie the winner hands priority to the other side
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            prio_fetch_q <= 1'b1;
        end else if (fetch_req_i && data_req_i) begin
            prio_fetch_q <= !prio_fetch_q;
        end
    end

    assign mem_req_o   = fetch_req_i || data_req_i;
    assign mem_we_o    = data_gnt_o && data_we_i;
    assign mem_addr_o  = data_gnt_o ? data_addr_i : fetch_addr_i;
    assign mem_wdata_o = data_wdata_i;
    assign mem_strb_o  = data_strb_i;

    // ############################
    // Return routing

    // Memory answers one cycle later, so the owner is just the delayed grant
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            fetch_rvalid_o <= 1'b0;
            data_rvalid_o  <= 1'b0;
        end else begin
            fetch_rvalid_o <= fetch_gnt_o;
            data_rvalid_o  <= data_gnt_o;
        end
    end

    assign rdata_o = mem_rdata_i;

    // ############################
    // Checks

    a_one_grant : assert property (
        @(posedge clk_i) disable iff (rst_i) !(fetch_gnt_o && data_gnt_o)
    ) else $error("fetch and data granted together");

endmodule : mem_arbiter

// ==== tests/mem_checker.sv ====
// ############################
// Samples on the falling edge, when inputs and outputs are settled
// Byte model assumes 8-byte lines, 4-byte blocks and a 4-byte instruction
// ############################

`timescale 1ns/1ps

module mem_checker #(
    parameter int unsigned MemAddrWidth = 12
) (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic [2:0]                       phase_i,

    input  logic                             fetch_req_i,
    input  logic [MemAddrWidth-3:0]          fetch_pc_i,
    input  logic                             fetch_gnt_i,
    input  logic                             fetch_rvalid_i,
    input  bgpu_mem_pkg::imem_line_t         fetch_line_i,

    input  logic                             data_req_i,
    input  logic                             data_we_i,
    input  logic [MemAddrWidth-1:0]          data_addr_i,
    input  bgpu_mem_pkg::block_data_t        data_wdata_i,
    input  bgpu_mem_pkg::block_mask_t        data_be_i,
    input  logic                             data_gnt_i,
    input  logic                             data_rvalid_i,
    input  bgpu_mem_pkg::block_data_t        data_rdata_i,

    output int                               value_errors_o,
    output int                               handshake_errors_o,
    output int                               reads_checked_o
);
    localparam int unsigned PcWidth = MemAddrWidth - 2;

    // Reference memory, one entry per byte
    logic [7:0] mem_bytes [1 << MemAddrWidth] = '{default: '0};

    // Arbitration model, fetch holds priority after reset
    logic prio_fetch = 1'b1;

    // Expected returns for the next cycle
    logic                      fetch_rvalid_exp = 1'b0;
    logic                      data_rvalid_exp  = 1'b0;
    bgpu_mem_pkg::imem_line_t  line_q [$];
    bgpu_mem_pkg::block_data_t block_q [$];
    logic                      data_read_q [$];

    int value_errors     = 0;
    int handshake_errors = 0;
    int reads_checked    = 0;

    assign value_errors_o     = value_errors;
    assign handshake_errors_o = handshake_errors;
    assign reads_checked_o    = reads_checked;

    // ############################
    // Model helpers

    function automatic string test_name(input logic [2:0] phase);
        case (phase)
            3'd0:    return "reset_idle";
            3'd1:    return "write_read";
            3'd2:    return "fetch_line";
            3'd3:    return "contention";
            3'd4:    return "random_mix";
            default: return "unknown";
        endcase
    endfunction

    // Little endian, byte 0 of the block sits in the low bits
    function automatic bgpu_mem_pkg::block_data_t model_block(input logic [MemAddrWidth-1:0] addr);
        bgpu_mem_pkg::block_data_t value;
        for (int unsigned b = 0; b < 4; b++) begin
            value[b*8 +: 8] = mem_bytes[addr + MemAddrWidth'(b)];
        end
        return value;
    endfunction

    // PC bit 0 picks the instruction inside the line, so it is dropped here
    function automatic bgpu_mem_pkg::imem_line_t model_line(input logic [PcWidth-1:0] pc);
        bgpu_mem_pkg::imem_line_t value;
        logic [MemAddrWidth-1:0]  base;
        base = {pc[PcWidth-1:1], 3'b000};
        for (int unsigned b = 0; b < 8; b++) begin
            value[b*8 +: 8] = mem_bytes[base + MemAddrWidth'(b)];
        end
        return value;
    endfunction

    task automatic apply_write(input logic [MemAddrWidth-1:0] addr,
                               input bgpu_mem_pkg::block_data_t wdata,
                               input bgpu_mem_pkg::block_mask_t be);
        for (int unsigned b = 0; b < 4; b++) begin
            if (be[b]) begin
                mem_bytes[addr + MemAddrWidth'(b)] = wdata[b*8 +: 8];
            end
        end
    endtask

    task automatic value_mismatch(input string what, input logic [63:0] expected,
                                  input logic [63:0] actual);
        value_errors++;
        $display("[FAIL] %s: %s expected %0h actual %0h",
                 test_name(phase_i), what, expected, actual);
    endtask

    task automatic handshake_mismatch(input string what, input logic [63:0] expected,
                                      input logic [63:0] actual);
        handshake_errors++;
        $display("[FAIL] %s: %s expected %0h actual %0h",
                 test_name(phase_i), what, expected, actual);
    endtask

    // ############################
    // Per-cycle comparison

    always @(negedge clk_i) begin : check_cycle
        logic                      exp_fetch_gnt;
        logic                      exp_data_gnt;
        logic                      was_read;
        bgpu_mem_pkg::imem_line_t  exp_line;
        bgpu_mem_pkg::block_data_t exp_block;

        // Returns belonging to the previous cycle's accepts
        if (fetch_rvalid_i !== fetch_rvalid_exp) begin
            handshake_mismatch("fetch rvalid", 64'(fetch_rvalid_exp), 64'(fetch_rvalid_i));
        end
        if (fetch_rvalid_exp && line_q.size() != 0) begin
            exp_line = line_q.pop_front();
            if (fetch_rvalid_i === 1'b1) begin
                reads_checked++;
                if (fetch_line_i !== exp_line) begin
                    value_mismatch("fetch line", 64'(exp_line), 64'(fetch_line_i));
                end
            end
        end

        if (data_rvalid_i !== data_rvalid_exp) begin
            handshake_mismatch("data rvalid", 64'(data_rvalid_exp), 64'(data_rvalid_i));
        end
        if (data_rvalid_exp && block_q.size() != 0) begin
            was_read  = data_read_q.pop_front();
            exp_block = block_q.pop_front();
            if (data_rvalid_i === 1'b1 && was_read) begin
                reads_checked++;
                if (data_rdata_i !== exp_block) begin
                    value_mismatch("data read block", 64'(exp_block), 64'(data_rdata_i));
                end
            end
        end

        // Grants of this cycle against the alternating rule
        if (fetch_req_i && data_req_i) begin
            exp_fetch_gnt = prio_fetch;
            exp_data_gnt  = !prio_fetch;
        end else begin
            exp_fetch_gnt = fetch_req_i;
            exp_data_gnt  = data_req_i;
        end
        if (fetch_gnt_i !== exp_fetch_gnt) begin
            handshake_mismatch("fetch grant", 64'(exp_fetch_gnt), 64'(fetch_gnt_i));
        end
        if (data_gnt_i !== exp_data_gnt) begin
            handshake_mismatch("data grant", 64'(exp_data_gnt), 64'(data_gnt_i));
        end

        if (rst_i) begin
            prio_fetch       = 1'b1;
            fetch_rvalid_exp = 1'b0;
            data_rvalid_exp  = 1'b0;
            line_q.delete();
            block_q.delete();
            data_read_q.delete();
        end else begin
            if (fetch_req_i && data_req_i) begin
                prio_fetch = !prio_fetch;
            end

            fetch_rvalid_exp = exp_fetch_gnt;
            if (fetch_rvalid_exp) begin
                line_q.push_back(model_line(fetch_pc_i));
            end

            data_rvalid_exp = exp_data_gnt;
            if (data_rvalid_exp) begin
                if (data_we_i) begin
                    apply_write(data_addr_i, data_wdata_i, data_be_i);
                    data_read_q.push_back(1'b0);
                    block_q.push_back('0);
                end else begin
                    data_read_q.push_back(1'b1);
                    block_q.push_back(model_block(data_addr_i));
                end
            end
        end
    end : check_cycle

endmodule : mem_checker

// ==== tests/tb_top.sv ====
// ############################
// Inputs change 1 ns after the rising edge
// Random traffic stays in a small window so reads hit written bytes
// ############################

`timescale 1ns/1ps

module tb_top;

    localparam int unsigned MemAddrWidth = 12;
    localparam int unsigned PcWidth      = MemAddrWidth - bgpu_mem_pkg::InstOffsetBits;
    localparam int unsigned ClkPeriodNs  = 10;
    localparam int unsigned ResetCycles  = 16;
    localparam int unsigned IdleCycles   = 16;

    // Transactions per test, used for the watchdog bound
    localparam int unsigned WriteReadTxns  = 40 + 32;
    localparam int unsigned FetchLines     = 8;
    localparam int unsigned FetchLineTxns  = FetchLines * 5;
    localparam int unsigned ContendEach    = 30;
    localparam int unsigned MixFetches     = 200;
    localparam int unsigned MixDataOps     = 300;
    localparam int unsigned TotalTxns      = WriteReadTxns + FetchLineTxns + 2 * ContendEach
                                             + MixFetches + MixDataOps;
    localparam int unsigned CyclesPerTxn   = 8;
    localparam int unsigned TimeoutNs      = (ResetCycles + 2 * IdleCycles
                                             + TotalTxns * CyclesPerTxn) * ClkPeriodNs;

    // Address windows
    localparam int unsigned WriteReadMask = 32'h0000_007C;
    localparam int unsigned MixAddrMask   = 32'h0000_00FC;
    localparam int unsigned MixPcMask     = 32'h0000_003F;

    logic                      clk;
    logic                      rst;
    logic [2:0]                phase;
    logic                      fetch_req;
    logic [PcWidth-1:0]        fetch_pc;
    logic                      fetch_gnt;
    logic                      fetch_rvalid;
    bgpu_mem_pkg::imem_line_t  fetch_line;
    logic                      data_req;
    logic                      data_we;
    logic [MemAddrWidth-1:0]   data_addr;
    bgpu_mem_pkg::block_data_t data_wdata;
    bgpu_mem_pkg::block_mask_t data_be;
    logic                      data_gnt;
    logic                      data_rvalid;
    bgpu_mem_pkg::block_data_t data_rdata;
    int                        value_errors;
    int                        handshake_errors;
    int                        reads_checked;

    always #(ClkPeriodNs / 2) clk = ~clk;

    bgpu_mem_top #(
        .MemAddrWidth( MemAddrWidth )
    ) DUT (
        .clk_i         ( clk          ),
        .rst_i         ( rst          ),
        .fetch_req_i   ( fetch_req    ),
        .fetch_pc_i    ( fetch_pc     ),
        .fetch_gnt_o   ( fetch_gnt    ),
        .fetch_rvalid_o( fetch_rvalid ),
        .fetch_line_o  ( fetch_line   ),
        .data_req_i    ( data_req     ),
        .data_we_i     ( data_we      ),
        .data_addr_i   ( data_addr    ),
        .data_wdata_i  ( data_wdata   ),
        .data_be_i     ( data_be      ),
        .data_gnt_o    ( data_gnt     ),
        .data_rvalid_o ( data_rvalid  ),
        .data_rdata_o  ( data_rdata   )
    );

    mem_checker #(
        .MemAddrWidth( MemAddrWidth )
    ) i_checker (
        .clk_i             ( clk              ),
        .rst_i             ( rst              ),
        .phase_i           ( phase            ),
        .fetch_req_i       ( fetch_req        ),
        .fetch_pc_i        ( fetch_pc         ),
        .fetch_gnt_i       ( fetch_gnt        ),
        .fetch_rvalid_i    ( fetch_rvalid     ),
        .fetch_line_i      ( fetch_line       ),
        .data_req_i        ( data_req         ),
        .data_we_i         ( data_we          ),
        .data_addr_i       ( data_addr        ),
        .data_wdata_i      ( data_wdata       ),
        .data_be_i         ( data_be          ),
        .data_gnt_i        ( data_gnt         ),
        .data_rvalid_i     ( data_rvalid      ),
        .data_rdata_i      ( data_rdata       ),
        .value_errors_o    ( value_errors     ),
        .handshake_errors_o( handshake_errors ),
        .reads_checked_o   ( reads_checked    )
    );

    // ############################
    // Drivers

    task automatic step_to_drive_point();
        @(posedge clk);
        #1;
    endtask

    // Holds the request until the grant is seen, then releases it
    task automatic fetch_access(input logic [PcWidth-1:0] pc);
        fetch_req = 1'b1;
        fetch_pc  = pc;
        @(negedge clk);
        while (fetch_gnt !== 1'b1) begin
            @(negedge clk);
        end
        step_to_drive_point();
        fetch_req = 1'b0;
    endtask

    task automatic data_access(input logic we, input logic [MemAddrWidth-1:0] addr,
                               input bgpu_mem_pkg::block_data_t wdata,
                               input bgpu_mem_pkg::block_mask_t be);
        data_req   = 1'b1;
        data_we    = we;
        data_addr  = addr;
        data_wdata = wdata;
        data_be    = be;
        @(negedge clk);
        while (data_gnt !== 1'b1) begin
            @(negedge clk);
        end
        step_to_drive_point();
        data_req = 1'b0;
        data_we  = 1'b0;
    endtask

    task automatic random_fetches(input int unsigned count, input int unsigned max_gap);
        int unsigned        gap;
        logic [PcWidth-1:0] pc;
        for (int unsigned i = 0; i < count; i++) begin
            gap = $urandom_range(max_gap, 0);
            repeat (gap) step_to_drive_point();
            pc = PcWidth'($urandom() & MixPcMask);
            fetch_access(pc);
        end
    endtask

    task automatic random_data_ops(input int unsigned count, input int unsigned max_gap);
        int unsigned             gap;
        logic                    we;
        logic [MemAddrWidth-1:0] addr;
        for (int unsigned i = 0; i < count; i++) begin
            gap = $urandom_range(max_gap, 0);
            repeat (gap) step_to_drive_point();
            we   = 1'($urandom_range(1, 0));
            addr = MemAddrWidth'($urandom() & MixAddrMask);
            data_access(we, addr, $urandom(), bgpu_mem_pkg::block_mask_t'($urandom()));
        end
    endtask

    // ############################
    // Test sequence

    initial begin : stimulus
        logic [MemAddrWidth-1:0] base;

        void'($urandom(32'hdcbc));
        clk        = 1'b0;
        rst        = 1'b1;
        phase      = 3'd0;
        fetch_req  = 1'b0;
        fetch_pc   = '0;
        data_req   = 1'b0;
        data_we    = 1'b0;
        data_addr  = '0;
        data_wdata = '0;
        data_be    = '0;

        repeat (ResetCycles) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (IdleCycles) step_to_drive_point();

        // Masked writes, then every block of the window read back
        phase = 3'd1;
        for (int unsigned i = 0; i < 40; i++) begin
            data_access(1'b1, MemAddrWidth'($urandom() & WriteReadMask), $urandom(),
                        bgpu_mem_pkg::block_mask_t'($urandom()));
        end
        for (int unsigned i = 0; i < 32; i++) begin
            data_access(1'b0, MemAddrWidth'(i * 4), '0, '0);
        end

        // Two blocks written, the first one rewritten, then both halves of the line fetched
        phase = 3'd2;
        for (int unsigned i = 0; i < FetchLines; i++) begin
            base = MemAddrWidth'(32'h200 + i * 8);
            data_access(1'b1, base, $urandom(), 4'hF);
            data_access(1'b1, base + MemAddrWidth'(4), $urandom(), 4'hF);
            data_access(1'b1, base, $urandom(), bgpu_mem_pkg::block_mask_t'($urandom()));
            fetch_access(PcWidth'(base >> 2));
            fetch_access(PcWidth'((base >> 2) + 1));
        end

        // Both sources back to back
        phase = 3'd3;
        fork
            random_fetches(ContendEach, 0);
            random_data_ops(ContendEach, 0);
        join

        phase = 3'd4;
        fork
            random_fetches(MixFetches, 3);
            random_data_ops(MixDataOps, 3);
        join

        repeat (IdleCycles) step_to_drive_point();
        $display("Error counts: %0d value, %0d handshake, %0d reads checked",
                 value_errors, handshake_errors, reads_checked);
        if (value_errors == 0 && handshake_errors == 0 && reads_checked > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end : stimulus

    initial begin : watchdog
        #(TimeoutNs);
        $display("Timeout: the run did not finish within %0d ns", TimeoutNs);
        $display("RESULT: FAIL");
        $finish;
    end : watchdog

endmodule : tb_top

// ==== vlog.f ====
src/bgpu_mem_pkg.sv
src/ifetch_port.sv
src/data_port.sv
src/mem_arbiter.sv
src/dummy_mem.sv
src/bgpu_mem_top.sv
tests/mem_checker.sv
tests/tb_top.sv
